/* all.f */
+incdir+testbench
verilog/alu_pkg.sv
verilog/exec_pkg.sv
verilog/alu.sv
verilog/exec_lane.sv
verilog/issue_dispatch.sv
verilog/result_merge.sv
verilog/exec_cluster.sv
testbench/tb_exec_cluster.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - verilog/alu_pkg.sv
  - verilog/exec_pkg.sv
  - verilog/alu.sv
  - verilog/exec_lane.sv
  - verilog/issue_dispatch.sv
  - verilog/result_merge.sv
  - verilog/exec_cluster.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_exec_cluster.sv

/* testbench/tb_alu_model.svh */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Expected result of one issue record, written from the opcode table
function automatic result_t model_result(
    input logic [tag_w-1:0] tag,
    input logic [4:0]       op,
    input logic [xlen-1:0]  a,
    input logic [xlen-1:0]  b
);
    result_t r;
    r.tag = tag;
    r.value = '0;
    r.fault = 1'b0;
    case (op)
        5'b00000: r.value = a + b; // add
        5'b01000: r.value = a - b; // sub
        5'b00001: r.value = a << b[4:0];
        5'b00101: r.value = a >> b[4:0];
        5'b01101: r.value = $signed(a) >>> b[4:0];
        5'b00010: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        5'b00011: r.value = (a < b) ? 32'd1 : 32'd0;
        5'b00100: r.value = a ^ b;
        5'b00110: r.value = a | b;
        5'b00111: r.value = a & b;
        5'b10000: r.value = (a == b) ? 32'd1 : 32'd0; // beq
        5'b10001: r.value = (a != b) ? 32'd1 : 32'd0;
        5'b10100: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        5'b10101: r.value = ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
        5'b10110: r.value = (a < b) ? 32'd1 : 32'd0; // bltu
        5'b10111: r.value = (a >= b) ? 32'd1 : 32'd0;
        default: begin
            r.fault = 1'b1; // Undefined code, value is don't care
        end
    endcase
    return r;
endfunction

task automatic check_value(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
);
    if (expected !== actual) begin
        $display("** Error %s: expected 0x%08h, actual 0x%08h at cycle %0d",
                 name, expected, actual, cycle);
        value_errors++;
    end
endtask

`endif

/* testbench/tb_exec_cluster.sv */
`default_nettype none

module tb_exec_cluster
    import alu_pkg::*, exec_pkg::*;
();

    localparam int seed = 52644;
    localparam int num_records = 400;
    localparam int out_depth = 3; // Credits the sink grants after reset
    localparam int stall_at = 200;
    localparam int stall_len = 30;
    localparam int timeout_cycles = num_records * 12 + 200;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    issue_t  in_issue;
    logic    in_credit;
    logic    out_valid;
    result_t out_res;
    logic    out_credit;

    int      cycle = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;
    int      in_cnt = in_credits; // Input credits held upstream
    int      out_held = 0; // Granted output credits not yet used
    int      sent = 0;
    int      outputs_seen = 0;
    int      first_out_cycle = 0;
    bit      stall = 1'b0;
    bit      stall_done = 1'b0;
    result_t expected_q[$];
    int      credit_due_q[$]; // Cycle at which each credit goes back
    int      credit_delay[num_records]; // Sink delay after each output

    `include "tb_alu_model.svh"

    exec_cluster dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_issue   (in_issue),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [xlen-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0: return '0;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    // Retries steer most picks onto defined codes
    function automatic logic [4:0] pick_op();
        logic [4:0] code;
        result_t    probe;
        code = 5'($urandom);
        for (int i = 0; i < 3; i++) begin
            probe = model_result('0, code, '0, '0);
            if (probe.fault) begin
                code = 5'($urandom);
            end
        end
        return code;
    endfunction

    task automatic send_record();
        issue_t rec;
        rec.tag = tag_w'(sent);
        rec.op = alu_op_e'(pick_op());
        rec.a = pick_operand();
        rec.b = ($urandom_range(0, 7) == 0) ? rec.a : pick_operand();
        in_valid = 1'b1;
        in_issue = rec;
        expected_q.push_back(model_result(rec.tag, rec.op, rec.a, rec.b));
        in_cnt--;
        sent++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
        in_valid = 1'b0;
        out_credit = 1'b0;
        if (!stall && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
            out_credit = 1'b1;
            out_held++;
            void'(credit_due_q.pop_front());
        end
    endtask

    task automatic try_issue();
        if (sent < num_records && in_cnt > 0 && $urandom_range(0, 1) == 1) begin
            send_record();
        end
    endtask

    always @(negedge clk) begin : monitor
        result_t exp;
        if (rst_n) begin
            if (in_credit) begin
                in_cnt++;
                if (in_cnt > in_credits) begin
                    $display("More input credits returned than issued at cycle %0d", cycle);
                    protocol_errors++;
                end
            end
            if (out_valid) begin
                if (out_held == 0) begin
                    $display("Output sent without an output credit at cycle %0d", cycle);
                    protocol_errors++;
                end else begin
                    out_held--;
                end
                if (expected_q.size() == 0) begin
                    $display("Extra output with tag %0d at cycle %0d", out_res.tag, cycle);
                    protocol_errors++;
                end else begin
                    exp = expected_q.pop_front();
                    check_value($sformatf("tag of output %0d", outputs_seen), exp.tag,
                                out_res.tag);
                    check_value($sformatf("fault of tag %0d", exp.tag), exp.fault,
                                out_res.fault);
                    if (!exp.fault) begin
                        check_value($sformatf("value of tag %0d", exp.tag), exp.value,
                                    out_res.value);
                    end
                end
                if (outputs_seen == 0) begin
                    first_out_cycle = cycle;
                end
                if (outputs_seen < num_records) begin
                    credit_due_q.push_back(cycle + 1 + credit_delay[outputs_seen]);
                end
                outputs_seen++;
            end
        end
    end

    initial begin : watchdog
        while (cycle < timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d results received",
                 cycle, outputs_seen, num_records);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int held_at_start;
        int stall_start;
        int latency_start;
        void'($urandom(seed));
        foreach (credit_delay[i]) begin
            credit_delay[i] = $urandom_range(0, 3);
        end
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_issue = '0;
        out_credit = 1'b0;
        repeat (out_depth) credit_due_q.push_back(0);
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;
        repeat (6) next_cycle(); // Sink credits granted and pipeline idle
        next_cycle();
        send_record();
        latency_start = cycle;
        while (outputs_seen == 0) next_cycle();
        check_value("latency", 3, first_out_cycle - latency_start);
        while (sent < num_records) begin
            if (sent == stall_at && !stall_done) begin
                stall = 1'b1; // Sink holds back all credits
                held_at_start = out_held;
                stall_start = outputs_seen;
                repeat (stall_len) begin
                    next_cycle();
                    try_issue();
                end
                check_value("outputs during stall", held_at_start, outputs_seen - stall_start);
                stall = 1'b0;
                stall_done = 1'b1;
            end else begin
                next_cycle();
                try_issue();
            end
        end
        while (outputs_seen < num_records) next_cycle();
        repeat (10) next_cycle(); // Catch extras and late credits
        check_value("input credits returned", in_credits, in_cnt);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/exec_cluster.sv */
`default_nettype none

module exec_cluster
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  issue_t  in_issue,
    output logic    in_credit,
    output logic    out_valid,
    output result_t out_res,
    input  logic    out_credit
);

    logic [1:0]    lane_valid;
    issue_t [1:0]  lane_issue;
    logic [1:0]    lane_credit;
    logic [1:0]    res_valid;
    result_t [1:0] lane_res;

    issue_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_issue    (in_issue),
        .in_credit   (in_credit),
        .lane_valid  (lane_valid),
        .lane_issue  (lane_issue),
        .lane_credit (lane_credit)
    );

    exec_lane lane0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_valid[0]),
        .lane_issue (lane_issue[0]),
        .res_valid  (res_valid[0]),
        .res        (lane_res[0])
    );

    exec_lane lane1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_valid[1]),
        .lane_issue (lane_issue[1]),
        .res_valid  (res_valid[1]),
        .res        (lane_res[1])
    );

    result_merge u_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_valid   (res_valid),
        .res         (lane_res),
        .lane_credit (lane_credit),
        .out_valid   (out_valid),
        .out_res     (out_res),
        .out_credit  (out_credit)
    );

endmodule

`default_nettype wire

/* verilog/result_merge.sv */
`default_nettype none

module result_merge
    import exec_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [1:0]       res_valid,
    input  result_t [1:0]    res,
    output logic [1:0]       lane_credit,
    output logic             out_valid,
    output result_t          out_res,
    input  logic             out_credit
);

    logic [out_cnt_w-1:0] out_cnt;
    logic                 turn; // Follows the dispatcher alternation
    logic                 send;
    logic [1:0]           not_empty;
    result_t [1:0]        head;

    // Only the lane whose turn it is may send
    assign send = not_empty[turn] && (out_cnt != '0);

    assign out_valid = send;
    assign out_res = head[turn];

    for (genvar k = 0; k < 2; k++) begin : g_lane
        result_t               fifo_mem [lane_credits];
        logic [lane_ptr_w-1:0] wr_ptr;
        logic [lane_ptr_w-1:0] rd_ptr;
        logic [lane_cnt_w-1:0] count;
        logic                  pop;

        assign pop = send && (turn == 1'(k));

        assign not_empty[k] = (count != '0);
        assign head[k] = fifo_mem[rd_ptr];
        assign lane_credit[k] = pop; // Slot freed, credit back to dispatch

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (res_valid[k]) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + lane_cnt_w'(res_valid[k]) - lane_cnt_w'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (res_valid[k]) begin
                fifo_mem[wr_ptr] <= res[k];
            end
        end
    end

    // Output credits start empty, downstream grants its depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_cnt <= '0;
            turn <= 1'b0;
        end else begin
            out_cnt <= out_cnt + out_cnt_w'(out_credit) - out_cnt_w'(send);
            if (send) begin
                turn <= ~turn;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/issue_dispatch.sv */
`default_nettype none

module issue_dispatch
    import exec_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  issue_t           in_issue,
    output logic             in_credit,
    output logic [1:0]       lane_valid,
    output issue_t [1:0]     lane_issue,
    input  logic [1:0]       lane_credit
);

    issue_t                          buf_mem [in_credits];
    logic [in_ptr_w-1:0]             wr_ptr;
    logic [in_ptr_w-1:0]             rd_ptr;
    logic [in_cnt_w-1:0]             count;
    logic [1:0][lane_cnt_w-1:0]      lane_cnt;
    logic                            turn; // Lane that gets the next record
    logic                            fire;
    issue_t                          head;

    assign head = buf_mem[rd_ptr];

    // Strict alternation, a stalled lane blocks the other
    assign fire = (count != '0) && (lane_cnt[turn] != '0);

    assign lane_valid[0] = fire & ~turn;
    assign lane_valid[1] = fire & turn;
    assign lane_issue[0] = head;
    assign lane_issue[1] = head;

    assign in_credit = fire; // Slot freed as the record leaves

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            turn <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fire) begin
                rd_ptr <= rd_ptr + 1'b1;
                turn <= ~turn;
            end
            count <= count + in_cnt_w'(in_valid) - in_cnt_w'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_mem[wr_ptr] <= in_issue;
        end
    end

    // Per-lane credit counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 2; k++) begin
                lane_cnt[k] <= lane_cnt_w'(lane_credits);
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                lane_cnt[k] <= lane_cnt[k] + lane_cnt_w'(lane_credit[k])
                               - lane_cnt_w'(lane_valid[k]);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_lane.sv */
`default_nettype none

module exec_lane
    import alu_pkg::*, exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    lane_valid,
    input  issue_t  lane_issue,
    output logic    res_valid,
    output result_t res
);

    logic [xlen-1:0] alu_out;
    logic            alu_fault;

    alu u_alu (
        .op    (lane_issue.op),
        .in_a  (lane_issue.a),
        .in_b  (lane_issue.b),
        .out   (alu_out),
        .fault (alu_fault)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= lane_valid; // One cycle through the lane
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (lane_valid) begin
            res.tag <= lane_issue.tag;
            res.value <= alu_out;
            res.fault <= alu_fault;
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu
    import alu_pkg::*;
(
    input  alu_op_e         op,
    input  logic [xlen-1:0] in_a,
    input  logic [xlen-1:0] in_b,
    output logic [xlen-1:0] out,
    output logic            fault
);

    logic            sub_mode;
    logic            shift_right;
    logic            shift_arith;
    logic            cmp_unsigned;
    logic            cmp_eq_ne;
    logic            cmp_invert;
    logic [4:0]      shamt;
    logic [xlen-1:0] b_adj;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] xor_res;
    logic [xlen-1:0] shift_res;
    logic            msb_diff;
    logic            eq;
    logic            lt;
    logic            cmp_res;

    // Opcode field decode
    assign sub_mode = (op != op_add); // Sub and all compares subtract
    assign shift_right = op[2];
    assign shift_arith = op[2] & op[3];
    assign cmp_unsigned = (~op[4] & op[0]) | (op[2] & op[1]);
    assign cmp_eq_ne = op[4] & ~op[2];
    assign cmp_invert = op[4] & op[0]; // bne, bge, bgeu

    // Adder with inverted b and carry in for subtraction
    assign b_adj = in_b ^ {xlen{sub_mode}};
    assign sum = in_a + b_adj + {{(xlen-1){1'b0}}, sub_mode};

    assign xor_res = in_a ^ in_b;

    assign shamt = in_b[4:0];

    always_comb begin
        if (!shift_right) begin
            shift_res = in_a << shamt;
        end else if (shift_arith) begin
            shift_res = $signed(in_a) >>> shamt;
        end else begin
            shift_res = in_a >> shamt;
        end
    end

    // Compare from the difference, sign bits settle mixed-sign cases
    assign eq = (xor_res == '0);
    assign msb_diff = in_a[xlen-1] ^ in_b[xlen-1];

    always_comb begin
        if (msb_diff) begin
            lt = cmp_unsigned ? in_b[xlen-1] : in_a[xlen-1];
        end else begin
            lt = sum[xlen-1];
        end
    end

    assign cmp_res = (cmp_eq_ne ? eq : lt) ^ cmp_invert;

    // Result select
    always_comb begin
        out = '0;
        fault = 1'b0;
        case (op)
            op_add, op_sub: begin
                out = sum;
            end
            op_sll, op_srl, op_sra: begin
                out = shift_res;
            end
            op_xor: begin
                out = xor_res;
            end
            op_or: begin
                out = in_a | in_b;
            end
            op_and: begin
                out = in_a & in_b;
            end
            op_slt, op_sltu, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                out = {{(xlen-1){1'b0}}, cmp_res};
            end
            default: begin
                fault = 1'b1; // Undefined encoding
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    import alu_pkg::*;

    localparam int tag_w = 8; // Sequence tag width
    localparam int in_credits = 4; // Dispatch buffer depth
    localparam int lane_credits = 2; // Merge FIFO depth per lane

    localparam int in_ptr_w = $clog2(in_credits);
    localparam int in_cnt_w = $clog2(in_credits + 1);
    localparam int lane_ptr_w = $clog2(lane_credits);
    localparam int lane_cnt_w = $clog2(lane_credits + 1);
    localparam int out_cnt_w = 8; // Output credits held by the merge unit

    typedef struct packed {
        logic [tag_w-1:0] tag;
        alu_op_e          op;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
    } issue_t; // 77 bits

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
        logic             fault; // Undefined opcode seen
    } result_t; // 41 bits

endpackage

`default_nettype wire

/* verilog/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    localparam int xlen = 32; // Operand and result width

    // Opcode encoding shared with the issue side
    typedef enum logic [4:0] {
        op_add  = 5'b00000,
        op_sll  = 5'b00001,
        op_slt  = 5'b00010,
        op_sltu = 5'b00011,
        op_xor  = 5'b00100,
        op_srl  = 5'b00101,
        op_or   = 5'b00110,
        op_and  = 5'b00111,
        op_sub  = 5'b01000,
        op_sra  = 5'b01101,
        op_beq  = 5'b10000,
        op_bne  = 5'b10001,
        op_blt  = 5'b10100,
        op_bge  = 5'b10101,
        op_bltu = 5'b10110,
        op_bgeu = 5'b10111
    } alu_op_e;

    // Any code outside the list above is undefined and faults

endpackage

`default_nettype wire
